// File: hdl/cpu_ring_tracker.sv
`include "dma_macros.svh"

module cpu_ring_tracker (
    input  logic [`RB_AWIDTH-1:0] head,
    input  logic [`RB_AWIDTH-1:0] tail,
    input  logic [30:0]           rb_size,
    input  flit_pkg::pdu_addr_t   size,
    output logic [`RB_AWIDTH-1:0] free_slot,
    output logic [`RB_AWIDTH-1:0] new_tail,
    output logic                  wrap,
    output flit_pkg::pdu_addr_t   size_low,
    output flit_pkg::pdu_addr_t   size_high
);

    logic [31:0] head_w;
    logic [31:0] tail_w;
    logic [31:0] size_w;
    logic [31:0] rb_size_w;
    logic [31:0] end_w;
    logic [31:0] free_w;
    logic [31:0] low_w;
    logic [31:0] tail_next_w;

    // work in 32 bits so none of the sums overflow
    assign head_w = 32'(head);
    assign tail_w = 32'(tail);
    assign size_w = 32'(size);
    assign rb_size_w = {1'b0, rb_size};
    assign end_w = tail_w + size_w;

    // one slot stays empty so a full ring differs from an empty one
    assign free_w = (tail_w >= head_w) ? (rb_size_w - tail_w + head_w - 32'd1)
                                       : (head_w - tail_w - 32'd1);
    assign free_slot = free_w[`RB_AWIDTH-1:0];

    // ending exactly at rb_size still fits in one transfer
    assign wrap = (end_w > rb_size_w);

    // split sizes, only meaningful when wrap is set
    assign low_w = rb_size_w - tail_w;
    assign size_low = low_w[`PDU_AWIDTH-1:0];
    assign size_high = size - size_low;

    assign tail_next_w = (end_w >= rb_size_w) ? (end_w - rb_size_w) : end_w;
    assign new_tail = tail_next_w[`RB_AWIDTH-1:0];

endmodule

// File: hdl/desc_pkg.sv
package desc_pkg;

    // write data mover descriptor, 174 bits, msb first
    typedef struct packed {
        logic [7:0]  func_nb;
        logic [7:0]  desc_id;
        logic [1:0]  app_spec;
        logic [7:0]  reserved;
        logic        single_src;
        // saddr_data holds the payload itself when set
        logic        immediate;
        logic [17:0] nb_dwords;
        logic [63:0] dst_addr;
        logic [63:0] saddr_data;
    } wrdm_desc_t;

    // which descriptor the builder should form
    typedef enum logic [1:0] {
        DESC_FULL,
        DESC_LOW,
        DESC_HIGH,
        DESC_DONE
    } desc_kind_e;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_QUEUE,
        DESC,
        DESC_WRAP,
        DONE
    } ctrl_state_e;

endpackage

// File: hdl/dma_ctrl_fsm.sv
`include "dma_macros.svh"

module dma_ctrl_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dma_start,
    input  flit_pkg::pdu_addr_t   dma_size,
    input  flit_pkg::pdu_addr_t   dma_base_addr,
    input  logic                  queue_ready,
    input  logic [`RB_AWIDTH-1:0] free_slot,
    input  logic [`RB_AWIDTH-1:0] new_tail,
    input  logic                  wrap,
    input  logic                  wrdm_desc_ready,
    input  desc_pkg::wrdm_desc_t  desc_data,
    output flit_pkg::pdu_addr_t   job_size,
    output flit_pkg::pdu_addr_t   job_base,
    output desc_pkg::desc_kind_e  desc_kind,
    output logic                  wrdm_desc_valid,
    output desc_pkg::wrdm_desc_t  wrdm_desc_data,
    output logic [`RB_AWIDTH-1:0] out_tail,
    output logic                  dma_done,
    output logic [31:0]           dma_queue_full_cnt
);

    desc_pkg::ctrl_state_e state;

    logic ready_r1;
    logic ready_r2;
    logic ready_q;
    logic fits;

    // ready acts three cycles late, so it must have held two cycles ago too
    assign ready_q = wrdm_desc_ready && ready_r2;
    assign fits = (free_slot >= `RB_AWIDTH'(job_size));

    always_comb begin
        case (state)
            desc_pkg::DESC:      desc_kind = wrap ? desc_pkg::DESC_LOW : desc_pkg::DESC_FULL;
            desc_pkg::DESC_WRAP: desc_kind = desc_pkg::DESC_HIGH;
            desc_pkg::DONE:      desc_kind = desc_pkg::DESC_DONE;
            default:             desc_kind = desc_pkg::DESC_FULL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == desc_pkg::IDLE && dma_start) begin
            job_size <= dma_size;
            job_base <= dma_base_addr;
        end
        wrdm_desc_data <= desc_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= desc_pkg::IDLE;
            ready_r1 <= 1'b0;
            ready_r2 <= 1'b0;
            wrdm_desc_valid <= 1'b0;
            dma_done <= 1'b0;
            out_tail <= '0;
            dma_queue_full_cnt <= '0;
        end else begin
            ready_r1 <= wrdm_desc_ready;
            ready_r2 <= ready_r1;
            wrdm_desc_valid <= 1'b0;
            dma_done <= 1'b0;
            case (state)
                desc_pkg::IDLE: begin
                    if (dma_start) begin
                        state <= desc_pkg::WAIT_QUEUE;
                    end
                end
                desc_pkg::WAIT_QUEUE: begin
                    if (queue_ready) begin
                        state <= desc_pkg::DESC;
                    end
                end
                desc_pkg::DESC: begin
                    if (ready_q && fits) begin
                        wrdm_desc_valid <= 1'b1;
                        state <= wrap ? desc_pkg::DESC_WRAP : desc_pkg::DONE;
                    end
                end
                desc_pkg::DESC_WRAP: begin
                    if (ready_q) begin
                        wrdm_desc_valid <= 1'b1;
                        state <= desc_pkg::DONE;
                    end
                end
                desc_pkg::DONE: begin
                    if (ready_q) begin
                        wrdm_desc_valid <= 1'b1;
                        dma_done <= 1'b1;
                        out_tail <= new_tail;
                        state <= desc_pkg::IDLE;
                    end
                end
                default: state <= desc_pkg::IDLE;
            endcase
            // stall count covers every descriptor-issuing state
            if (!ready_q && (state == desc_pkg::DESC || state == desc_pkg::DESC_WRAP ||
                             state == desc_pkg::DONE)) begin
                dma_queue_full_cnt <= dma_queue_full_cnt + 32'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        wrdm_desc_valid |-> $past(wrdm_desc_ready) && $past(wrdm_desc_ready, 3))
        else $error("descriptor issued without qualified ready");

    assert property (@(posedge clk) disable iff (rst)
        dma_done |-> wrdm_desc_valid && wrdm_desc_data.immediate)
        else $error("dma_done without the done descriptor");

endmodule

// File: hdl/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// flit geometry on the FPGA side
`define FLIT_BITS          512
`define PDU_AWIDTH         8
`define PDU_DEPTH          256

// slot index width of the host ring
`define RB_AWIDTH          12

// flit memory as seen by the write data mover
`define EP_BASE_ADDR       32'h0004_0000
`define RB_BRAM_OFFSET     0

`define DONE_ID            8'hFE
`define JOB_FIFO_DEPTH     4
`define ALMOST_FULL_MARGIN 32

`endif

// File: hdl/flit_pkg.sv
`include "dma_macros.svh"

package flit_pkg;

    // one data word of the FPGA ring
    typedef logic [`FLIT_BITS-1:0] flit_t;

    // flit index into the FPGA ring, also used for sizes in flits
    typedef logic [`PDU_AWIDTH-1:0] pdu_addr_t;

    // a block committed by the producer, waiting to be moved
    typedef struct packed {
        pdu_addr_t base;
        pdu_addr_t size;
    } job_t;

endpackage

// File: hdl/fpga2cpu_dma.sv
`include "dma_macros.svh"

module fpga2cpu_dma (
    input  logic                  clk,
    input  logic                  rst,
    // producer side of the FPGA ring
    input  flit_pkg::flit_t       wr_data,
    input  flit_pkg::pdu_addr_t   wr_addr,
    input  logic                  wr_en,
    output flit_pkg::pdu_addr_t   wr_base_addr,
    output logic                  wr_base_addr_valid,
    output logic                  almost_full,
    input  logic                  update_valid,
    input  flit_pkg::pdu_addr_t   update_size,
    // host ring state
    input  logic [`RB_AWIDTH-1:0] head,
    input  logic [`RB_AWIDTH-1:0] tail,
    input  logic [63:0]           kmem_addr,
    input  logic                  queue_ready,
    input  logic [30:0]           rb_size,
    output logic [`RB_AWIDTH-1:0] out_tail,
    output logic                  dma_done,
    output logic                  dma_start,
    // write data mover descriptor port
    input  logic                  wrdm_desc_ready,
    output logic                  wrdm_desc_valid,
    output desc_pkg::wrdm_desc_t  wrdm_desc_data,
    // write data mover read port
    output flit_pkg::flit_t       frb_readdata,
    output logic                  frb_readvalid,
    input  flit_pkg::pdu_addr_t   frb_address,
    input  logic                  frb_read,
    output logic [31:0]           dma_queue_full_cnt
);

    flit_pkg::pdu_addr_t   dma_size;
    flit_pkg::pdu_addr_t   dma_base_addr;
    flit_pkg::pdu_addr_t   job_size;
    flit_pkg::pdu_addr_t   job_base;
    flit_pkg::pdu_addr_t   size_low;
    flit_pkg::pdu_addr_t   size_high;
    logic [`RB_AWIDTH-1:0] free_slot;
    logic [`RB_AWIDTH-1:0] new_tail;
    logic                  wrap;
    desc_pkg::desc_kind_e  desc_kind;
    desc_pkg::wrdm_desc_t  desc_data;

    pdu_ring_buffer pdu_ring_buffer_i (
        .clk(clk), .rst(rst),
        .wr_data(wr_data), .wr_addr(wr_addr), .wr_en(wr_en),
        .update_valid(update_valid), .update_size(update_size),
        .rd_addr(frb_address), .rd_en(frb_read), .dma_done(dma_done),
        .wr_base_addr(wr_base_addr), .wr_base_addr_valid(wr_base_addr_valid),
        .almost_full(almost_full),
        .rd_data(frb_readdata), .rd_valid(frb_readvalid),
        .dma_start(dma_start), .dma_size(dma_size), .dma_base_addr(dma_base_addr)
    );

    cpu_ring_tracker cpu_ring_tracker_i (
        .head(head), .tail(tail), .rb_size(rb_size), .size(job_size),
        .free_slot(free_slot), .new_tail(new_tail), .wrap(wrap),
        .size_low(size_low), .size_high(size_high)
    );

    wrdm_desc_builder wrdm_desc_builder_i (
        .kind(desc_kind), .kmem_addr(kmem_addr), .tail(tail), .new_tail(new_tail),
        .base(job_base), .size(job_size), .size_low(size_low), .size_high(size_high),
        .desc_data(desc_data)
    );

    dma_ctrl_fsm dma_ctrl_fsm_i (
        .clk(clk), .rst(rst),
        .dma_start(dma_start), .dma_size(dma_size), .dma_base_addr(dma_base_addr),
        .queue_ready(queue_ready), .free_slot(free_slot), .new_tail(new_tail),
        .wrap(wrap), .wrdm_desc_ready(wrdm_desc_ready), .desc_data(desc_data),
        .job_size(job_size), .job_base(job_base), .desc_kind(desc_kind),
        .wrdm_desc_valid(wrdm_desc_valid), .wrdm_desc_data(wrdm_desc_data),
        .out_tail(out_tail), .dma_done(dma_done),
        .dma_queue_full_cnt(dma_queue_full_cnt)
    );

endmodule

// File: hdl/pdu_ring_buffer.sv
`include "dma_macros.svh"

module pdu_ring_buffer (
    input  logic                clk,
    input  logic                rst,
    input  flit_pkg::flit_t     wr_data,
    input  flit_pkg::pdu_addr_t wr_addr,
    input  logic                wr_en,
    input  logic                update_valid,
    input  flit_pkg::pdu_addr_t update_size,
    input  flit_pkg::pdu_addr_t rd_addr,
    input  logic                rd_en,
    input  logic                dma_done,
    output flit_pkg::pdu_addr_t wr_base_addr,
    output logic                wr_base_addr_valid,
    output logic                almost_full,
    output flit_pkg::flit_t     rd_data,
    output logic                rd_valid,
    output logic                dma_start,
    output flit_pkg::pdu_addr_t dma_size,
    output flit_pkg::pdu_addr_t dma_base_addr
);

    localparam int JQ_AW = $clog2(`JOB_FIFO_DEPTH);
    localparam logic [JQ_AW:0] JQ_FULL = `JOB_FIFO_DEPTH;
    localparam logic [`PDU_AWIDTH:0] FREE_ALL = `PDU_DEPTH;
    localparam logic [`PDU_AWIDTH:0] AF_MARGIN = `ALMOST_FULL_MARGIN;

    flit_pkg::flit_t mem [`PDU_DEPTH];
    flit_pkg::job_t  job_q [`JOB_FIFO_DEPTH];

    logic [JQ_AW-1:0]     jq_wr_ptr;
    logic [JQ_AW-1:0]     jq_rd_ptr;
    logic [JQ_AW:0]       jq_count;
    logic [`PDU_AWIDTH:0] free_cnt;
    logic [`PDU_AWIDTH:0] used_flits;
    logic [`PDU_AWIDTH:0] freed_flits;
    logic                 busy;
    logic                 issue;
    logic                 push;
    logic                 pop;
    flit_pkg::pdu_addr_t  wr_ptr;
    flit_pkg::job_t       new_job;
    flit_pkg::job_t       next_job;
    flit_pkg::flit_t      rd_data_r;
    logic                 rd_en_r;

    assign wr_ptr = wr_base_addr + wr_addr;
    assign new_job = '{base: wr_base_addr, size: update_size};

    // start a job when idle, or in the same cycle the previous one finishes
    assign issue = (!busy || dma_done) && (jq_count != '0 || update_valid);
    assign pop = issue && (jq_count != '0);
    // an empty queue lets the committed job go straight to the controller
    assign push = update_valid && !(issue && jq_count == '0);
    assign next_job = (jq_count != '0) ? job_q[jq_rd_ptr] : new_job;

    assign used_flits = update_valid ? {1'b0, update_size} : '0;
    assign freed_flits = dma_done ? {1'b0, dma_size} : '0;

    assign wr_base_addr_valid = (jq_count != JQ_FULL);
    assign almost_full = (free_cnt < AF_MARGIN);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (push) begin
            job_q[jq_wr_ptr] <= new_job;
        end
        if (issue) begin
            dma_size <= next_job.size;
            dma_base_addr <= next_job.base;
        end
        rd_data_r <= mem[rd_addr];
        rd_data <= rd_data_r;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_base_addr <= '0;
            free_cnt <= FREE_ALL;
            jq_wr_ptr <= '0;
            jq_rd_ptr <= '0;
            jq_count <= '0;
            busy <= 1'b0;
            dma_start <= 1'b0;
            rd_en_r <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (update_valid) begin
                wr_base_addr <= wr_base_addr + update_size;
            end
            free_cnt <= free_cnt - used_flits + freed_flits;
            if (push) begin
                jq_wr_ptr <= jq_wr_ptr + 1'b1;
            end
            if (pop) begin
                jq_rd_ptr <= jq_rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                jq_count <= jq_count + 1'b1;
            end else if (pop && !push) begin
                jq_count <= jq_count - 1'b1;
            end
            if (issue) begin
                busy <= 1'b1;
            end else if (dma_done) begin
                busy <= 1'b0;
            end
            dma_start <= issue;
            rd_en_r <= rd_en;
            rd_valid <= rd_en_r;
        end
    end

    // producer must wait for a free job slot before committing
    assert property (@(posedge clk) disable iff (rst) update_valid |-> wr_base_addr_valid)
        else $error("update_valid while job queue full");

endmodule

// File: hdl/wrdm_desc_builder.sv
`include "dma_macros.svh"

module wrdm_desc_builder (
    input  desc_pkg::desc_kind_e  kind,
    input  logic [63:0]           kmem_addr,
    input  logic [`RB_AWIDTH-1:0] tail,
    input  logic [`RB_AWIDTH-1:0] new_tail,
    input  flit_pkg::pdu_addr_t   base,
    input  flit_pkg::pdu_addr_t   size,
    input  flit_pkg::pdu_addr_t   size_low,
    input  flit_pkg::pdu_addr_t   size_high,
    output desc_pkg::wrdm_desc_t  desc_data
);

    logic [63:0] cpu_addr;
    logic [63:0] cpu_addr_high;
    logic [63:0] ep_addr;
    logic [63:0] ep_addr_high;

    // slot 0 of the host ring holds the tail, data starts one flit in
    assign cpu_addr = kmem_addr + (64'(tail) << 6) + 64'd64;
    assign cpu_addr_high = kmem_addr + 64'd64;

    // byte address of the job's first flit inside the endpoint memory
    assign ep_addr = 64'(`EP_BASE_ADDR) + ((64'(`RB_BRAM_OFFSET) + 64'(base)) << 6);
    assign ep_addr_high = ep_addr + (64'(size_low) << 6);

    always_comb begin
        desc_data = '0;
        case (kind)
            desc_pkg::DESC_LOW: begin
                desc_data.nb_dwords = 18'({size_low, 4'h0});
                desc_data.dst_addr = cpu_addr;
                desc_data.saddr_data = ep_addr;
            end
            desc_pkg::DESC_HIGH: begin
                desc_data.nb_dwords = 18'({size_high, 4'h0});
                desc_data.dst_addr = cpu_addr_high;
                desc_data.saddr_data = ep_addr_high;
            end
            desc_pkg::DESC_DONE: begin
                // immediate write of the new tail into slot 0
                desc_data.desc_id = `DONE_ID;
                desc_data.immediate = 1'b1;
                desc_data.nb_dwords = 18'd1;
                desc_data.dst_addr = kmem_addr;
                desc_data.saddr_data = 64'(new_tail);
            end
            default: begin
                // 16 dwords per flit
                desc_data.nb_dwords = 18'({size, 4'h0});
                desc_data.dst_addr = cpu_addr;
                desc_data.saddr_data = ep_addr;
            end
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fpga2cpu_dma testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module fpga2cpu_dma_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: testbench/fpga2cpu_dma_patterns.txt
// size head tail rb_size kmem_addr ready_drop data_desc_count new_tail
// one job per line, all hex
04 000 000 00000040 0000000100000000 00 1 004
08 004 004 00000040 0000000100000000 05 1 00C
0A 010 03C 00000040 0000000100000000 00 2 006
04 010 03C 00000040 0000000100000000 00 1 000
08 00C 00A 00000040 0000000100000000 00 1 012
20 020 0F0 00000100 0000000080001000 03 2 010
10 000 100 00000800 0000000080001000 02 1 110

// File: testbench/fpga2cpu_dma_tb.sv
`include "dma_macros.svh"

module fpga2cpu_dma_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_JOBS = 32;

    logic clk = 1'b0;
    logic rst = 1'b1;
    flit_pkg::flit_t wr_data = '0;
    flit_pkg::pdu_addr_t wr_addr = '0;
    logic wr_en = 1'b0;
    logic update_valid = 1'b0;
    flit_pkg::pdu_addr_t update_size = '0;
    logic [`RB_AWIDTH-1:0] head = '0;
    logic [`RB_AWIDTH-1:0] tail = '0;
    logic [63:0] kmem_addr = '0;
    logic queue_ready = 1'b1;
    logic [30:0] rb_size = 31'd64;
    logic wrdm_desc_ready = 1'b1;
    flit_pkg::pdu_addr_t frb_address = '0;
    logic frb_read = 1'b0;
    flit_pkg::pdu_addr_t wr_base_addr;
    logic wr_base_addr_valid, almost_full, dma_done, dma_start, wrdm_desc_valid, frb_readvalid;
    logic [`RB_AWIDTH-1:0] out_tail;
    desc_pkg::wrdm_desc_t wrdm_desc_data;
    flit_pkg::flit_t frb_readdata;
    logic [31:0] dma_queue_full_cnt;

    logic [63:0] pat [MAX_JOBS*8];
    flit_pkg::flit_t model_mem [`PDU_DEPTH];
    desc_pkg::wrdm_desc_t desc_q[$];
    flit_pkg::pdu_addr_t rd_req_q[$];
    logic [1:0] pipe_v = '0;
    flit_pkg::pdu_addr_t pipe_a [2];
    logic [2:0] rdy_hist = '0;
    logic done_seen = 1'b0;
    logic [`RB_AWIDTH-1:0] tail_at_done;
    flit_pkg::pdu_addr_t exp_base = '0;
    logic [31:0] lcg_state = 32'd62;
    int cycles = 0, cycle_limit = 0, fail_count = 0, num_jobs = 0;

    fpga2cpu_dma fpga2cpu_dma_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic make_flit(output flit_pkg::flit_t f);
        for (int i = 0; i < 16; i++) begin
            lcg_state = lcg_next(lcg_state);
            f[i*32 +: 32] = lcg_state;
        end
    endtask

    task automatic compare_value(input string name, input logic [511:0] got,
                                 input logic [511:0] exp);
        assert (got === exp) else begin
            fail_count++;
            $display("ERROR time %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic require_true(input logic cond, input string msg);
        assert (cond) else begin
            fail_count++;
            $display("time %0t: %s", $time, msg);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic verify_desc(input int idx, input logic [7:0] id, input logic imm,
                               input logic [63:0] nb, input logic [63:0] dst,
                               input logic [63:0] src);
        desc_pkg::wrdm_desc_t d;
        d = desc_q[idx];
        compare_value("wrdm_desc_data.desc_id", 512'(d.desc_id), 512'(id));
        compare_value("wrdm_desc_data.immediate", 512'(d.immediate), 512'(imm));
        compare_value("wrdm_desc_data.nb_dwords", 512'(d.nb_dwords), 512'(nb[17:0]));
        compare_value("wrdm_desc_data.dst_addr", 512'(d.dst_addr), 512'(dst));
        compare_value("wrdm_desc_data.saddr_data", 512'(d.saddr_data), 512'(src));
    endtask

    // ready history as the DUT samples it at each rising edge
    always @(posedge clk) begin
        rdy_hist <= {rdy_hist[1:0], wrdm_desc_ready};
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    // write data mover model that collects descriptors and reads back the flits
    always @(negedge clk) begin : mover
        logic [63:0] flit_idx;
        int nflits;
        if (!rst) begin
            require_true(frb_readvalid === pipe_v[1],
                         "read data did not return two cycles after its read");
            if (pipe_v[1]) begin
                compare_value("frb_readdata", frb_readdata, model_mem[pipe_a[1]]);
            end
            pipe_v[1] = pipe_v[0];
            pipe_a[1] = pipe_a[0];
            if (wrdm_desc_valid) begin
                require_true(rdy_hist[0] && rdy_hist[2],
                             "descriptor issued without qualified ready");
                desc_q.push_back(wrdm_desc_data);
                if (!wrdm_desc_data.immediate) begin
                    flit_idx = ((wrdm_desc_data.saddr_data - 64'(`EP_BASE_ADDR)) >> 6)
                               - 64'(`RB_BRAM_OFFSET);
                    nflits = int'(wrdm_desc_data.nb_dwords >> 4);
                    for (int j = 0; j < nflits; j++) begin
                        rd_req_q.push_back(flit_idx[7:0] + 8'(j));
                    end
                end
            end
            if (dma_done) begin
                require_true(wrdm_desc_valid, "dma_done without a descriptor");
                done_seen = 1'b1;
                tail_at_done = out_tail;
            end
            frb_read = (rd_req_q.size() > 0);
            if (frb_read) begin
                frb_address = rd_req_q.pop_front();
            end
            pipe_v[0] = frb_read;
            pipe_a[0] = frb_address;
        end
    end

    task automatic run_job(input int n);
        logic [63:0] size, rb, low, free_slots, drop, cnt, nt, cnt_before, src;
        logic wrap;
        flit_pkg::flit_t f;
        size = pat[n*8];
        rb = pat[n*8+3];
        drop = pat[n*8+5];
        cnt = pat[n*8+6];
        nt = pat[n*8+7];
        head = pat[n*8+1][`RB_AWIDTH-1:0];
        tail = pat[n*8+2][`RB_AWIDTH-1:0];
        rb_size = rb[30:0];
        kmem_addr = pat[n*8+4];
        wrap = (64'(tail) + size > rb);
        low = rb - 64'(tail);
        compare_value("wr_base_addr", 512'(wr_base_addr), 512'(exp_base));
        // every earlier block has been freed by now
        compare_value("almost_full", 512'(almost_full), 512'(0));
        for (int k = 0; k < int'(size); k++) begin
            make_flit(f);
            wr_data = f;
            wr_addr = 8'(k);
            wr_en = 1'b1;
            model_mem[exp_base + 8'(k)] = f;
            @(negedge clk);
        end
        wr_en = 1'b0;
        desc_q.delete();
        done_seen = 1'b0;
        update_valid = 1'b1;
        update_size = size[7:0];
        @(negedge clk);
        update_valid = 1'b0;
        while (!dma_start) @(negedge clk);
        // the committed block is held until dma_done
        compare_value("almost_full", 512'(almost_full),
                      512'(64'(`PDU_DEPTH) - size < 64'(`ALMOST_FULL_MARGIN)));
        cnt_before = 64'(dma_queue_full_cnt);
        if (drop != 0) begin
            wrdm_desc_ready = 1'b0;
            repeat (int'(drop)) @(negedge clk);
            wrdm_desc_ready = 1'b1;
        end
        // one host slot always stays empty
        free_slots = (tail >= head) ? rb - 64'(tail) + 64'(head) - 64'd1
                                    : 64'(head) - 64'(tail) - 64'd1;
        if (free_slots < size) begin
            repeat (20) @(negedge clk);
            require_true(desc_q.size() == 0,
                         "descriptor issued while host ring lacked free slots");
            head = tail;
        end
        while (!done_seen) @(negedge clk);
        compare_value("data descriptor count", 512'(wrap ? 2 : 1), 512'(cnt));
        compare_value("descriptor count", 512'(desc_q.size()), 512'(cnt + 64'd1));
        src = 64'(`EP_BASE_ADDR) + ((64'(`RB_BRAM_OFFSET) + 64'(exp_base)) << 6);
        verify_desc(0, 8'h00, 1'b0, (wrap ? low : size) << 4,
                    kmem_addr + (64'(tail) << 6) + 64'd64, src);
        if (wrap) begin
            verify_desc(1, 8'h00, 1'b0, (size - low) << 4, kmem_addr + 64'd64,
                        src + (low << 6));
        end
        verify_desc(int'(cnt), `DONE_ID, 1'b1, 64'd1, kmem_addr, nt);
        compare_value("out_tail", 512'(tail_at_done), 512'(nt));
        require_true(64'(dma_queue_full_cnt) - cnt_before >= drop,
                     "dma_queue_full_cnt grew less than the ready drop length");
        while (rd_req_q.size() != 0 || pipe_v != 2'b00) @(negedge clk);
        exp_base = exp_base + size[7:0];
    endtask

    initial begin
        for (int i = 0; i < MAX_JOBS*8; i++) begin
            pat[i] = '1;
        end
        $readmemh("testbench/fpga2cpu_dma_patterns.txt", pat);
        while (num_jobs < MAX_JOBS && pat[num_jobs*8] !== '1) begin
            num_jobs++;
        end
        require_true(num_jobs > 0, "pattern file holds no jobs");
        cycle_limit = num_jobs * 200;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare_value("wrdm_desc_valid", 512'(wrdm_desc_valid), 512'(0));
        compare_value("dma_done", 512'(dma_done), 512'(0));
        compare_value("dma_start", 512'(dma_start), 512'(0));
        compare_value("frb_readvalid", 512'(frb_readvalid), 512'(0));
        compare_value("out_tail", 512'(out_tail), 512'(0));
        compare_value("dma_queue_full_cnt", 512'(dma_queue_full_cnt), 512'(0));
        compare_value("wr_base_addr_valid", 512'(wr_base_addr_valid), 512'(1));
        for (int j = 0; j < num_jobs; j++) begin
            run_job(j);
        end
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/flit_pkg.sv
hdl/desc_pkg.sv
hdl/pdu_ring_buffer.sv
hdl/cpu_ring_tracker.sv
hdl/wrdm_desc_builder.sv
hdl/dma_ctrl_fsm.sv
hdl/fpga2cpu_dma.sv
testbench/fpga2cpu_dma_tb.sv
